// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = seq_core_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: host_regs.sv
`default_nettype none

module host_regs (
    input  wire                      clk,
    input  wire                      reset,
    input  wire seq_pkg::host_cmd_t  host_cmd,
    input  wire                      rd_req,
    input  wire seq_pkg::seq_state_e state,
    output logic                     wr_accept,
    output logic                     rd_valid,
    output seq_pkg::slot_wr_t        slot_wr,
    output logic                     ctrl_valid,
    output seq_pkg::ctrl_cmd_e       ctrl_cmd,
    output seq_pkg::slot_idx_t       end_cnt
);
    import seq_pkg::*;

    logic cfg_open;     // table and end count writable
    logic is_ctrl;
    logic is_end_cnt;
    logic is_slot;

    assign cfg_open = (state == st_shutdown);   // sequencer idle

    ////////////////////////////////////////////////////////////
    // target decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        is_ctrl    = 1'b0;
        is_end_cnt = 1'b0;
        is_slot    = 1'b0;
        if (host_cmd.valid) begin
            case (host_cmd.target)
                tgt_control: is_ctrl    = 1'b1;
                tgt_end_cnt: is_end_cnt = 1'b1;
                tgt_slot:    is_slot    = 1'b1;
                default:     is_ctrl    = 1'b0;   // spare code, refused
            endcase
        end
    end

    // control always gets through, config only while idle
    assign wr_accept = is_ctrl | (cfg_open & (is_end_cnt | is_slot));
    assign rd_valid  = rd_req & cfg_open;

    // slot write towards the table
    always_comb begin
        slot_wr.valid = is_slot & cfg_open;
        slot_wr.field = host_cmd.field;
        slot_wr.index = host_cmd.index;
        slot_wr.data  = host_cmd.data;
    end

    // commands go straight to the FSM, it acts on the next edge
    assign ctrl_valid = is_ctrl;
    assign ctrl_cmd   = ctrl_cmd_e'(host_cmd.data[1:0]);

    ////////////////////////////////////////////////////////////
    // end count
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            end_cnt <= '0;
        end else if (is_end_cnt && cfg_open) begin
            end_cnt <= host_cmd.data[SLOT_IDX_W-1:0];   // last slot of the walk
        end
    end

endmodule

`default_nettype wire

// File: project.f
seq_pkg.sv
host_regs.sv
slot_table.sv
task_sequencer.sv
seq_core.sv
tb_clock_gen.sv
seq_core_tb.sv

// File: seq_core.sv
`default_nettype none

module seq_core #(
    parameter int n_init_tasks = 4     // DMA init steps per run
) (
    input  wire                        clk,
    input  wire                        reset,
    // host side
    input  wire seq_pkg::host_cmd_t    host_cmd,
    input  wire                        rd_req,
    input  wire seq_pkg::slot_idx_t    rd_index,
    output wire                        wr_accept,
    output wire                        rd_valid,
    output wire seq_pkg::slot_entry_t  host_entry,
    output wire seq_pkg::seq_state_e   state,
    output wire seq_pkg::slot_idx_t    main_cnt,
    output wire seq_pkg::slot_idx_t    end_cnt,
    // DMA / reconfiguration side
    input  wire                        reprog_accept,
    input  wire [n_init_tasks-1:0]     init_fin,
    input  wire                        exec_accept,
    input  wire                        exec_fin,
    output wire                        reprog,
    output wire [n_init_tasks-1:0]     init_task,
    output wire                        exec_start,
    output wire seq_pkg::slot_entry_t  dma_entry    // row at main_cnt
);
    import seq_pkg::*;

    wire slot_wr_t  slot_wr;      // host -> table
    wire slot_wr_t  prof_wr;      // sequencer -> table
    wire            ctrl_valid;
    wire ctrl_cmd_e ctrl_cmd;

    ////////////////////////////////////////////////////////////
    // host front end
    ////////////////////////////////////////////////////////////
    host_regs u_host_regs (
        .clk        (clk),
        .reset      (reset),
        .host_cmd   (host_cmd),
        .rd_req     (rd_req),
        .state      (state),
        .wr_accept  (wr_accept),
        .rd_valid   (rd_valid),
        .slot_wr    (slot_wr),
        .ctrl_valid (ctrl_valid),
        .ctrl_cmd   (ctrl_cmd),
        .end_cnt    (end_cnt)
    );

    slot_table u_slot_table (
        .clk        (clk),
        .reset      (reset),
        .slot_wr    (slot_wr),
        .prof_wr    (prof_wr),
        .rd_index   (rd_index),
        .seq_index  (main_cnt),     // sequencer always reads the current slot
        .host_entry (host_entry),
        .seq_entry  (dma_entry)
    );

    task_sequencer #(
        .n_init_tasks (n_init_tasks)
    ) u_task_sequencer (
        .clk           (clk),
        .reset         (reset),
        .ctrl_valid    (ctrl_valid),
        .ctrl_cmd      (ctrl_cmd),
        .end_cnt       (end_cnt),
        .seq_entry     (dma_entry),
        .reprog_accept (reprog_accept),
        .init_fin      (init_fin),
        .exec_accept   (exec_accept),
        .exec_fin      (exec_fin),
        .state         (state),
        .main_cnt      (main_cnt),
        .prof_wr       (prof_wr),
        .reprog        (reprog),
        .init_task     (init_task),
        .exec_start    (exec_start)
    );

endmodule

`default_nettype wire

// File: seq_core_tb.sv
`default_nettype none

module seq_core_tb;
    import seq_pkg::*;

    localparam int n_init     = 4;      // init tasks per run
    localparam int wait_max   = 200;    // cycles before a wait gives up
    localparam int sel_reprog = -1;     // wait selectors, >= 0 means init bit
    localparam int sel_exec   = -2;
    localparam int sel_idle   = -3;
    localparam int sel_reset  = -4;

    typedef logic [147:0]      wide_t;      // one table row wide
    typedef logic [n_init-1:0] init_vec_t;

    logic        clk, reset;
    host_cmd_t   host_cmd;
    logic        rd_req;
    slot_idx_t   rd_index;
    logic        reprog_accept, exec_accept, exec_fin;
    init_vec_t   init_fin;
    logic        wr_accept, rd_valid, reprog, exec_start;
    slot_entry_t host_entry, dma_entry;
    seq_state_e  state;
    slot_idx_t   main_cnt, end_cnt;
    init_vec_t   init_task;

    slot_entry_t exp_slots [4];     // reference copy of the table
    profile_t    prof_start [4];    // profiles as first written
    int          checks, errors, timeouts;

    tb_clock_gen clkgen (.clk(clk), .reset(reset));

    seq_core #(.n_init_tasks(n_init)) uut (
        .clk(clk), .reset(reset), .host_cmd(host_cmd), .rd_req(rd_req), .rd_index(rd_index),
        .wr_accept(wr_accept), .rd_valid(rd_valid), .host_entry(host_entry), .state(state),
        .main_cnt(main_cnt), .end_cnt(end_cnt), .reprog_accept(reprog_accept),
        .init_fin(init_fin), .exec_accept(exec_accept), .exec_fin(exec_fin),
        .reprog(reprog), .init_task(init_task), .exec_start(exec_start), .dma_entry(dma_entry)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic init_vec_t bit_of(input int i);
        return init_vec_t'(1) << i;
    endfunction

    function automatic logic req_seen(input int sel);
        case (sel)
            sel_reprog: return reprog;
            sel_exec:   return exec_start;
            sel_idle:   return state == st_shutdown;
            sel_reset:  return reset;
            default:    return |(init_task & bit_of(sel));   // one init bit
        endcase
    endfunction

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic compare(input string name, input wide_t got, input wide_t exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;                            // drive and sample point
    endtask

    task automatic wait_req(input int sel, input string what);
        int n;
        n = 0;
        while (req_seen(sel) !== 1'b1 && n < wait_max) begin   // X counts as not yet
            next_cycle();
            n++;
        end
        if (req_seen(sel) !== 1'b1) begin
            $display("timeout: no %s within %0d cycles", what, wait_max);
            timeouts++;
            finish_run();
        end
    endtask

    task automatic dma_delay();
        repeat ($urandom_range(4, 1)) next_cycle();   // 1 to 4 cycles
    endtask

    ////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////
    task automatic host_write(input host_target_e tgt, input slot_field_e fld,
                              input slot_idx_t idx, input host_data_t data, input logic exp_acc);
        host_cmd.valid  = 1'b1;
        host_cmd.target = tgt;
        host_cmd.field  = fld;
        host_cmd.index  = idx;
        host_cmd.data   = data;
        #20;                                            // accept is combinational
        compare("wr_accept", wide_t'(wr_accept), wide_t'(exp_acc));
        next_cycle();
        host_cmd = '0;
    endtask

    task automatic send_cmd(input ctrl_cmd_e c);
        host_write(tgt_control, fld_src_addr, '0, host_data_t'(c), 1'b1);
    endtask

    // narrow fields keep the low bits of the write data
    task automatic model_write(input slot_field_e fld, input slot_idx_t idx, input host_data_t d);
        case (fld)
            fld_src_addr: exp_slots[idx].src_addr = d;
            fld_src_size: exp_slots[idx].src_size = d[SIZE_W-1:0];
            fld_dst_addr: exp_slots[idx].dst_addr = d;
            fld_dst_size: exp_slots[idx].dst_size = d[SIZE_W-1:0];
            default:      exp_slots[idx].profile  = d;
        endcase
    endtask

    task automatic read_check(input slot_idx_t idx);
        rd_index = idx;
        rd_req   = 1'b1;
        #20;
        compare("rd_valid", wide_t'(rd_valid), wide_t'(1));
        compare($sformatf("host_entry[%0d]", idx), host_entry, exp_slots[idx]);
        next_cycle();
        rd_req = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // DMA responder, one slot per call
    ////////////////////////////////////////////////////////////
    task automatic serve_slot(input slot_idx_t idx);
        wait_req(sel_reprog, "reprog");
        compare("main_cnt", wide_t'(main_cnt), wide_t'(idx));
        compare("init_task", wide_t'(init_task), '0);      // reprog comes first
        compare("dma_entry", dma_entry, exp_slots[idx]);
        dma_delay();
        compare("reprog", wide_t'(reprog), wide_t'(1));   // still held
        reprog_accept = 1'b1;
        next_cycle();
        reprog_accept = 1'b0;
        exp_slots[idx].profile = exp_slots[idx].profile + 1;   // one bump per run
        compare("dma_entry", dma_entry, exp_slots[idx]);
        for (int i = 0; i < n_init; i++) begin
            wait_req(i, "init_task bit");
            compare("init_task", wide_t'(init_task), wide_t'(bit_of(i)));
            dma_delay();
            compare("init_task", wide_t'(init_task), wide_t'(bit_of(i)));   // held until fin
            init_fin = bit_of(i);
            next_cycle();
            init_fin = '0;
        end
        wait_req(sel_exec, "exec_start");
        compare("init_task", wide_t'(init_task), '0);
        dma_delay();
        compare("exec_start", wide_t'(exec_start), wide_t'(1));   // held until accept
        exec_accept = 1'b1;
        next_cycle();
        exec_accept = 1'b0;
        compare("state", wide_t'(state), wide_t'(st_wait_fin));
        compare("exec_start", wide_t'(exec_start), '0);
        dma_delay();
        exec_fin = 1'b1;                // single-cycle finish
        next_cycle();
        exec_fin = 1'b0;
    endtask

    task automatic end_of_walk();
        wait_req(sel_idle, "return to shutdown");
        compare("main_cnt", wide_t'(main_cnt), '0);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic fill_table();
        slot_idx_t  s;
        host_data_t d;
        for (int i = 0; i < 4; i++) begin
            s = slot_idx_t'(i);
            for (int f = 0; f < 5; f++) begin
                d = $urandom();
                host_write(tgt_slot, slot_field_e'(f), s, d, 1'b1);
                model_write(slot_field_e'(f), s, d);
            end
            prof_start[s] = exp_slots[s].profile;
        end
        host_write(tgt_end_cnt, fld_src_addr, '0, 32'd2, 1'b1);   // walk slots 0..2
        compare("end_cnt", wide_t'(end_cnt), wide_t'(2));
        for (int i = 0; i < 4; i++) read_check(slot_idx_t'(i));
    endtask

    task automatic full_walk();
        send_cmd(cmd_start);
        for (int i = 0; i < 3; i++) serve_slot(slot_idx_t'(i));
        end_of_walk();
    endtask

    task automatic refuse_mid_run();
        send_cmd(cmd_start);
        serve_slot(2'd0);
        wait_req(sel_reprog, "reprog of slot 1");        // hold here, mid-run
        host_write(tgt_slot, fld_src_addr, 2'd3, 32'hdead_beef, 1'b0);
        host_write(tgt_slot, fld_profile, 2'd1, 32'h0, 1'b0);
        host_write(tgt_end_cnt, fld_src_addr, '0, 32'd3, 1'b0);
        compare("end_cnt", wide_t'(end_cnt), wide_t'(2));
        rd_index = 2'd1;                                   // no readback mid-run
        rd_req   = 1'b1;
        #20;
        compare("rd_valid", wide_t'(rd_valid), '0);
        next_cycle();
        rd_req = 1'b0;
        send_cmd(cmd_start);                               // no restart mid-run
        compare("main_cnt", wide_t'(main_cnt), wide_t'(1));
        compare("state", wide_t'(state), wide_t'(st_reprog));
        serve_slot(2'd1);
        serve_slot(2'd2);
        end_of_walk();
        for (int i = 0; i < 4; i++) read_check(slot_idx_t'(i));
    endtask

    task automatic profile_counts();
        slot_idx_t s;
        for (int i = 0; i < 4; i++) begin
            s = slot_idx_t'(i);
            read_check(s);
            compare($sformatf("profile[%0d]", i), wide_t'(host_entry.profile),
                    wide_t'(prof_start[s] + profile_t'(i < 3 ? 2 : 0)));
        end
    endtask

    task automatic abort_mid_run();
        send_cmd(cmd_start);
        serve_slot(2'd0);
        wait_req(sel_reprog, "reprog of slot 1");
        reprog_accept = 1'b1;
        next_cycle();
        reprog_accept = 1'b0;
        exp_slots[1].profile = exp_slots[1].profile + 1;
        wait_req(0, "init_task bit 0");
        send_cmd(cmd_shutdown);                            // abort inside the init chain
        compare("state", wide_t'(state), wide_t'(st_shutdown));
        compare("init_task", wide_t'(init_task), '0);
        compare("exec_start", wide_t'(exec_start), '0);
        compare("main_cnt", wide_t'(main_cnt), wide_t'(1)); // counter kept
        send_cmd(cmd_clear);
        compare("main_cnt", wide_t'(main_cnt), '0);
        compare("state", wide_t'(state), wide_t'(st_shutdown));
        for (int i = 0; i < 4; i++) read_check(slot_idx_t'(i));
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h0342_c2c6));
        host_cmd      = '0;
        rd_req        = 1'b0;
        rd_index      = '0;
        reprog_accept = 1'b0;
        init_fin      = '0;
        exec_accept   = 1'b0;
        exec_fin      = 1'b0;
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        for (int i = 0; i < 4; i++) begin
            exp_slots[i]  = '0;         // table comes out of reset empty
            prof_start[i] = '0;
        end
        wait_req(sel_reset, "reset release");
        next_cycle();
        fill_table();
        full_walk();
        refuse_mid_run();
        profile_counts();
        abort_mid_run();
        finish_run();
    end

endmodule

`default_nettype wire

// File: seq_pkg.sv
`default_nettype none

package seq_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int SLOT_IDX_W = 2;    // 4 slots
    localparam int ADDR_W     = 32;
    localparam int SIZE_W     = 26;
    localparam int PROFILE_W  = 32;

    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;    // slot index, also the walk counter
    typedef logic [ADDR_W-1:0]     addr_t;        // byte address
    typedef logic [SIZE_W-1:0]     size_t;        // transfer size
    typedef logic [PROFILE_W-1:0]  profile_t;     // runs done on one slot
    typedef logic [31:0]           host_data_t;   // narrow fields take the low bits

    // one table row, 148 bits
    typedef struct packed {
        addr_t    src_addr;
        size_t    src_size;
        addr_t    dst_addr;
        size_t    dst_size;
        profile_t profile;
    } slot_entry_t;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        fld_src_addr, fld_src_size, fld_dst_addr, fld_dst_size, fld_profile
    } slot_field_e;

    typedef enum logic [1:0] {tgt_control, tgt_end_cnt, tgt_slot} host_target_e;

    typedef enum logic [1:0] {cmd_clear, cmd_shutdown, cmd_start} ctrl_cmd_e;

    typedef enum logic [2:0] {
        st_shutdown, st_reprog, st_init, st_trigger, st_wait_fin
    } seq_state_e;

    typedef struct packed {
        logic         valid;
        host_target_e target;
        slot_field_e  field;    // only for tgt_slot
        slot_idx_t    index;    // only for tgt_slot
        host_data_t   data;     // command code sits in data[1:0]
    } host_cmd_t;               // 40 bits

    typedef struct packed {
        logic        valid;
        slot_field_e field;
        slot_idx_t   index;
        host_data_t  data;
    } slot_wr_t;                // 38 bits, one field per write

endpackage

`default_nettype wire

// File: slot_table.sv
`default_nettype none

module slot_table (
    input  wire                      clk,
    input  wire                      reset,
    input  wire seq_pkg::slot_wr_t   slot_wr,     // host side
    input  wire seq_pkg::slot_wr_t   prof_wr,     // sequencer side, profile only
    input  wire seq_pkg::slot_idx_t  rd_index,
    input  wire seq_pkg::slot_idx_t  seq_index,
    output seq_pkg::slot_entry_t     host_entry,
    output seq_pkg::slot_entry_t     seq_entry
);
    import seq_pkg::*;

    localparam int n_slots = 2 ** SLOT_IDX_W;

    slot_entry_t slots [n_slots];
    slot_wr_t    wr;              // merged write port

    // replace one field of a row
    function automatic slot_entry_t put_field(
        slot_entry_t e,
        slot_field_e f,
        host_data_t  d
    );
        slot_entry_t r;
        r = e;
        case (f)
            fld_src_addr: r.src_addr = d[ADDR_W-1:0];
            fld_src_size: r.src_size = d[SIZE_W-1:0];    // low bits only
            fld_dst_addr: r.dst_addr = d[ADDR_W-1:0];
            fld_dst_size: r.dst_size = d[SIZE_W-1:0];
            fld_profile:  r.profile  = d[PROFILE_W-1:0];
            default:      r = e;                          // bad field code, row kept
        endcase
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////
    assign wr = prof_wr.valid ? prof_wr : slot_wr;   // profile bump has priority

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < n_slots; i++) begin
                slots[i] <= '0;
            end
        end else if (wr.valid) begin
            slots[wr.index] <= put_field(slots[wr.index], wr.field, wr.data);
        end
    end

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////
    assign host_entry = slots[rd_index];    // host readback
    assign seq_entry  = slots[seq_index];   // current slot, to the DMA

    // the sequencer only ever touches the run counter
    prof_field_chk: assert property (@(posedge clk) disable iff (!reset)
        prof_wr.valid |-> (prof_wr.field == fld_profile));

    // host writes need shutdown, profile bumps need a run
    wr_clash_chk: assert property (@(posedge clk) disable iff (!reset)
        !(prof_wr.valid && slot_wr.valid));

endmodule

`default_nettype wire

// File: task_sequencer.sv
`default_nettype none

module task_sequencer #(
    parameter int n_init_tasks = 4
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        ctrl_valid,
    input  wire seq_pkg::ctrl_cmd_e    ctrl_cmd,
    input  wire seq_pkg::slot_idx_t    end_cnt,
    input  wire seq_pkg::slot_entry_t  seq_entry,
    input  wire                        reprog_accept,
    input  wire [n_init_tasks-1:0]     init_fin,
    input  wire                        exec_accept,
    input  wire                        exec_fin,       // single-cycle pulse
    output seq_pkg::seq_state_e        state,
    output seq_pkg::slot_idx_t         main_cnt,
    output seq_pkg::slot_wr_t          prof_wr,
    output logic                       reprog,
    output logic [n_init_tasks-1:0]    init_task,      // one-hot
    output logic                       exec_start
);
    import seq_pkg::*;

    localparam logic [n_init_tasks-1:0] init_first = 1;   // chain starts at bit 0

    logic cur_fin;      // finish on the active init bit
    logic accept_now;   // reprogram taken this cycle

    assign reprog     = (state == st_reprog);
    assign cur_fin    = |(init_fin & init_task);
    assign accept_now = reprog & reprog_accept & !ctrl_valid;   // a command wins

    ////////////////////////////////////////////////////////////
    // profile bump, one per run
    ////////////////////////////////////////////////////////////
    always_comb begin
        prof_wr.valid = accept_now;
        prof_wr.field = fld_profile;
        prof_wr.index = main_cnt;                          // row under seq_entry
        prof_wr.data  = seq_entry.profile + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // run FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state      <= st_shutdown;
            main_cnt   <= '0;
            init_task  <= '0;
            exec_start <= 1'b0;
        end else if (ctrl_valid) begin
            case (ctrl_cmd)
                cmd_clear: begin
                    state      <= st_shutdown;
                    main_cnt   <= '0;
                    init_task  <= '0;
                    exec_start <= 1'b0;
                end
                cmd_shutdown: begin
                    state      <= st_shutdown;   // main_cnt kept
                    init_task  <= '0;
                    exec_start <= 1'b0;
                end
                cmd_start: begin
                    if (state == st_shutdown) begin   // ignored mid-run
                        state    <= st_reprog;
                        main_cnt <= '0;
                    end
                end
                default: state <= state;          // spare code
            endcase
        end else begin
            case (state)
                st_shutdown: state <= st_shutdown;   // wait for start
                st_reprog: begin
                    if (reprog_accept) begin
                        state     <= st_init;
                        init_task <= init_first;
                    end
                end
                st_init: begin
                    if (cur_fin) begin
                        if (init_task[n_init_tasks-1]) begin   // last task done
                            state      <= st_trigger;
                            init_task  <= '0;
                            exec_start <= 1'b1;
                        end else begin
                            init_task <= init_task << 1;   // next task
                        end
                    end
                end
                st_trigger: begin
                    if (exec_accept) begin
                        state      <= st_wait_fin;
                        exec_start <= 1'b0;
                    end
                end
                st_wait_fin: begin
                    if (exec_fin) begin
                        if (main_cnt < end_cnt) begin
                            state    <= st_reprog;           // next slot
                            main_cnt <= main_cnt + 1'b1;
                        end else begin
                            state    <= st_shutdown;         // walk done
                            main_cnt <= '0;
                        end
                    end
                end
                default: state <= st_shutdown;   // recover from bad code
            endcase
        end
    end

    init_onehot_chk: assert property (@(posedge clk) disable iff (!reset)
        $onehot0(init_task));

    init_state_chk: assert property (@(posedge clk) disable iff (!reset)
        (init_task != '0) |-> (state == st_init));

    exec_state_chk: assert property (@(posedge clk) disable iff (!reset)
        exec_start |-> (state == st_trigger));

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset      // active low
);
    // 100 unit period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        reset = 1'b0;                 // held for 8 rising edges
        repeat (8) @(posedge clk);
        #5 reset = 1'b1;              // release just after an edge
    end

endmodule

`default_nettype wire
